// ==== Bender.yml ====
package:
  name: radio_core

sources:
  - common/radio_pkg.sv
  - radio_ctrl/radio_settings.sv
  - radio_ctrl/radio_readback.sv
  - src/timekeeper.sv
  - tx_wave/tx_codeword_gen.sv
  - src/radio_core.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/radio_core_sva.sv
      - bench/radio_core_tb.sv

// ==== bench/radio_core_sva.sv ====
/*
 * Radio core assertions
 * Idle word after run stops, codeword index range and the
 * steady count of the time counter
 */
`timescale 1ns/1ps

module radio_core_sva import radio_pkg::*; (
   input logic                i_clk,
   input logic                i_arst_n,
   input tx_ctrl_t            i_tx_ctrl,
   input logic [DATA_W-1:0]   i_idle_word,
   input logic [DATA_W-1:0]   i_tx,
   input logic [CW_IDX_W-1:0] i_cw_idx,
   input logic                i_pps,
   input time_set_t           i_time_set,
   input logic [TIME_W-1:0]   i_vita_time
);

   logic [CW_IDX_W-1:0] act_len;
   logic                imm_load;

   // Zero or out of range length means the whole table
   assign act_len = (i_tx_ctrl.length == '0 || i_tx_ctrl.length > CW_IDX_W'(N_CODEWORDS)) ?
                    CW_IDX_W'(N_CODEWORDS) : i_tx_ctrl.length;
   assign imm_load = i_time_set.load_stb & ~i_time_set.at_pps;

   idle_after_stop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $fell(i_tx_ctrl.run) |=> i_tx == $past(i_idle_word))
      else $error("o_tx is not the idle word after run was cleared");

   index_in_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_tx_ctrl.run && !i_tx_ctrl.wave_rst) |-> i_cw_idx < act_len)
      else $error("Codeword index %0d not below length %0d", i_cw_idx, act_len);

   // PPS edges may carry an armed load, so they are left out
   time_counts: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (!imm_load && !$rose(i_pps)) |=> i_vita_time == $past(i_vita_time) + 64'd1)
      else $error("vita_time did not advance by one");

endmodule

bind radio_core radio_core_sva u_sva (
   .i_clk       (bus_clk),
   .i_arst_n    (i_arst_n),
   .i_tx_ctrl   (tx_ctrl),
   .i_idle_word (idle_word),
   .i_tx        (o_tx),
   .i_cw_idx    (u_tx_gen.cw_idx),
   .i_pps       (i_pps),
   .i_time_set  (time_set),
   .i_vita_time (o_vita_time)
);

// ==== bench/radio_core_tb.sv ====
/*
 * Radio core testbench
 * Table of writes, reads, idles and PPS pulses applied in order,
 * with expected values worked out from the register timing
 */
`timescale 1ns/1ps

module radio_core_tb import radio_pkg::*; ();

   typedef enum logic [2:0] {
      OP_WRITE, OP_READ, OP_READ_RANGE, OP_READ_CHG,
      OP_IDLE, OP_PPS, OP_TX_SEQ, OP_TX_EQ
   } op_e;

   typedef struct packed {
      op_e               op;
      logic [ADDR_W-1:0] addr;   // Address, or readback select for reads
      logic [DATA_W-1:0] data;   // Write data or cycle count
      logic [TIME_W-1:0] exp;
   } row_t;

   logic              bus_clk;
   logic              arst_n;
   set_bus_t          set_bus;
   logic [DATA_W-1:0] rx_word;
   logic [DATA_W-1:0] tx_word;
   logic              pps;
   logic [TIME_W-1:0] rb_data;
   logic [TIME_W-1:0] vita_time;

   row_t              table_q[$];
   logic [DATA_W-1:0] cw[5];
   integer            seed = 32'h521a;
   int                errors = 0;
   int                cycles = 0;
   int                limit = 0;
   int                build_edges = 0;   // Edges used by the table so far
   int                load_edge;         // First edge showing load_val
   logic [TIME_W-1:0] load_val;
   logic [TIME_W-1:0] last_pps_rb = '0;

   tb_clock_gen clk_gen0 (
      .o_clk    (bus_clk),
      .o_arst_n (arst_n)
   );

   radio_core dut0 (
      .bus_clk     (bus_clk),
      .i_arst_n    (arst_n),
      .i_set       (set_bus),
      .i_rx        (rx_word),
      .i_pps       (pps),
      .o_tx        (tx_word),
      .o_rb_data   (rb_data),
      .o_vita_time (vita_time)
   );

   //////////////////////////////
   // Table building
   //////////////////////////////
   function automatic void push_row(op_e op, logic [ADDR_W-1:0] addr,
                                    logic [DATA_W-1:0] data, logic [TIME_W-1:0] exp);
      table_q.push_back(row_t'{op, addr, data, exp});
      case (op)
         OP_WRITE:                     build_edges += 2;
         OP_IDLE, OP_TX_SEQ, OP_TX_EQ: build_edges += int'(data);
         OP_PPS:                       build_edges += 5;
         default:                      build_edges += 3;   // Reads
      endcase
   endfunction

   function automatic void load_time_rows(logic [TIME_W-1:0] value, logic at_pps);
      push_row(OP_WRITE, SR_TIME_CTRL, {31'd0, at_pps}, '0);
      push_row(OP_WRITE, SR_TIME_HI, value[63:32], '0);
      if (!at_pps) begin
         load_val  = value;
         load_edge = build_edges + 3;   // Strobe edge, then one more
      end
      push_row(OP_WRITE, SR_TIME_LO, value[31:0], '0);
   endfunction

   // Readback samples the time at the second edge of the read
   function automatic void time_read_row();
      push_row(OP_READ, RB_TIME, '0, load_val + TIME_W'(build_edges + 2 - load_edge));
   endfunction

   function automatic void build_table();
      logic [TIME_W-1:0] t_imm = 64'h0000_0001_2345_6780;
      logic [TIME_W-1:0] t_pps = 64'h0000_0002_0000_0000;
      logic [DATA_W-1:0] test_val = 32'hA5C3_0F96;
      logic [DATA_W-1:0] idle_val = 32'hC0DE_1D1E;
      int c;
      push_row(OP_WRITE, SR_TEST, test_val, '0);
      push_row(OP_READ, RB_TEST, '0, {32'd0, test_val});
      for (c = 4; c < 8; c++)
         push_row(OP_READ, ADDR_W'(c), '0, '0);   // Unused codes and RB_ZERO
      // Immediate load, two reads 10 edges apart
      load_time_rows(t_imm, 1'b0);
      time_read_row();
      push_row(OP_IDLE, '0, 32'd7, '0);
      time_read_row();
      // Armed load, old count runs on until PPS
      load_time_rows(t_pps, 1'b1);
      time_read_row();
      push_row(OP_PPS, '0, '0, '0);
      push_row(OP_READ_RANGE, RB_TIME, '0, t_pps);
      push_row(OP_READ_CHG, RB_TIME_PPS, '0, '0);
      push_row(OP_PPS, '0, '0, '0);
      push_row(OP_READ_CHG, RB_TIME_PPS, '0, '0);
      // Codeword playback, then idle
      push_row(OP_WRITE, SR_CODEC_IDLE, idle_val, '0);
      for (c = 0; c < 5; c++)
         push_row(OP_WRITE, ADDR_W'(SR_CODEWORD0 + c), cw[c], '0);
      push_row(OP_WRITE, SR_CNTRL, 32'h0000_0502, '0);   // Run, length 5
      push_row(OP_TX_SEQ, '0, 32'd15, '0);
      push_row(OP_WRITE, SR_CNTRL, 32'd0, '0);
      push_row(OP_TX_EQ, '0, 32'd3, {32'd0, idle_val});
      // Loopback on and off
      push_row(OP_WRITE, SR_LOOPBACK, 32'd1, '0);
      push_row(OP_READ, RB_SAMPLES, '0, {idle_val, idle_val});
      push_row(OP_WRITE, SR_LOOPBACK, 32'd0, '0);
      push_row(OP_READ, RB_SAMPLES, '0, {idle_val, rx_word});
   endfunction

   //////////////////////////////
   // Bus and pin activity
   //////////////////////////////
   task automatic write_reg(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
      @(posedge bus_clk);
      set_bus <= {1'b1, addr, data};
      @(posedge bus_clk);   // Strobe taken here
      set_bus.stb <= 1'b0;
   endtask

   task automatic read_rb(logic [2:0] sel, output logic [TIME_W-1:0] value);
      write_reg(SR_READBACK, {29'd0, sel});
      @(posedge bus_clk);
      @(negedge bus_clk);
      value = rb_data;
   endtask

   task automatic pulse_pps();
      @(posedge bus_clk);
      pps <= 1'b1;
      repeat (3) @(posedge bus_clk);
      pps <= 1'b0;
      @(posedge bus_clk);
   endtask

   task automatic check_tx_seq(int n);
      int pos;
      int i;
      int k;
      pos = -1;
      for (i = 0; i < n; i++) begin
         @(posedge bus_clk);
         @(negedge bus_clk);
         if (pos < 0) begin
            for (k = 0; k < 5; k++)
               if (tx_word == cw[k])
                  pos = k;
            if (pos < 0) begin
               $display("ERROR %0t: o_tx %h is none of codewords 0 to 4", $time, tx_word);
               errors++;
               return;
            end
         end else begin
            pos = (pos + 1) % 5;
            if (tx_word !== cw[pos]) begin
               $display("ERROR %0t: o_tx %h, expected codeword %0d %h",
                        $time, tx_word, pos, cw[pos]);
               errors++;
            end
         end
      end
   endtask

   task automatic check_tx_word(int n, logic [DATA_W-1:0] exp);
      repeat (n) begin
         @(posedge bus_clk);
         @(negedge bus_clk);
         if (tx_word !== exp) begin
            $display("ERROR %0t: o_tx %h, expected %h", $time, tx_word, exp);
            errors++;
         end
      end
   endtask

   //////////////////////////////
   // Run and timeout
   //////////////////////////////
   always @(posedge bus_clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout, the table did not finish within %0d cycles", limit);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      int i;
      row_t r;
      logic [TIME_W-1:0] rd;
      set_bus = '0;
      pps     = 1'b0;
      rx_word = $random(seed);
      for (i = 0; i < 5; i++)
         cw[i] = $random(seed);
      build_table();
      limit = 4 * build_edges + 100;
      @(posedge arst_n);
      for (i = 0; i < table_q.size(); i++) begin
         r = table_q[i];
         case (r.op)
            OP_WRITE: write_reg(r.addr, r.data);
            OP_READ: begin
               read_rb(r.addr[2:0], rd);
               if (rd !== r.exp) begin
                  $display("ERROR %0t: row %0d read %h, expected %h", $time, i, rd, r.exp);
                  errors++;
               end
               // Live time runs one edge ahead of the registered readback
               if (r.addr[2:0] == RB_TIME && vita_time !== r.exp + 64'd1) begin
                  $display("ERROR %0t: row %0d vita_time %h, expected %h",
                           $time, i, vita_time, r.exp + 64'd1);
                  errors++;
               end
            end
            OP_READ_RANGE: begin
               read_rb(r.addr[2:0], rd);
               if (rd < r.exp || rd >= r.exp + 64'd50) begin
                  $display("ERROR %0t: row %0d time %h outside %h + 50", $time, i, rd, r.exp);
                  errors++;
               end
            end
            OP_READ_CHG: begin
               read_rb(r.addr[2:0], rd);
               if (rd === last_pps_rb) begin
                  $display("ERROR %0t: row %0d PPS time stuck at %h", $time, i, rd);
                  errors++;
               end
               last_pps_rb = rd;
            end
            OP_IDLE:   repeat (r.data) @(posedge bus_clk);
            OP_PPS:    pulse_pps();
            OP_TX_SEQ: check_tx_seq(int'(r.data));
            OP_TX_EQ:  check_tx_word(int'(r.data), r.exp[DATA_W-1:0]);
            default:   ;
         endcase
      end
      $display("Table done, %0d errors", errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 20 ns bus clock, reset held low for the first 10 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_arst_n
);

   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;
   end

   initial begin
      o_arst_n = 1'b0;
      repeat (10) @(posedge o_clk);
      o_arst_n <= 1'b1;   // Released on a rising edge
   end

endmodule

// ==== common/radio_pkg.sv ====
/*
 * Radio control package
 * Register map, readback select codes, widths and the structs
 * shared by the settings, timing and transmit blocks
 */
package radio_pkg;

   //////////////////////////////
   // Widths and sizes
   //////////////////////////////
   localparam int DATA_W      = 32;   // Settings data, codewords, samples
   localparam int ADDR_W      = 8;    // Setting address
   localparam int TIME_W      = 64;   // Time counter
   localparam int N_CODEWORDS = 20;
   localparam int CW_IDX_W    = 5;    // Enough for N_CODEWORDS

   //////////////////////////////
   // Register map
   //////////////////////////////
   typedef enum logic [ADDR_W-1:0] {
      SR_LOOPBACK   = 8'd6,
      SR_TEST       = 8'd21,
      SR_CODEC_IDLE = 8'd22,
      SR_READBACK   = 8'd32,
      SR_TIME_HI    = 8'd128,
      SR_TIME_LO    = 8'd129,   // Write here fires the time load
      SR_TIME_CTRL  = 8'd130,   // Bit 0 selects load at next PPS
      SR_CNTRL      = 8'd163,
      SR_CODEWORD0  = 8'd164    // Table runs up to 183
   } sr_addr_e;

   // Readback select, codes 4 to 6 read as zero too
   typedef enum logic [2:0] {
      RB_TEST     = 3'd0,
      RB_TIME     = 3'd1,
      RB_TIME_PPS = 3'd2,
      RB_SAMPLES  = 3'd3,
      RB_ZERO     = 3'd7
   } rb_sel_e;

   //////////////////////////////
   // Shared structs
   //////////////////////////////

   // Settings bus, stb is a single cycle write pulse
   typedef struct packed {
      logic              stb;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } set_bus_t;

   // Fields of the control register
   typedef struct packed {
      logic                wave_rst;   // Bit 0
      logic                run;        // Bit 1
      logic [CW_IDX_W-1:0] length;     // Bits 12:8, 0 or >20 means 20
   } tx_ctrl_t;

   // Pending time load towards the timekeeper
   typedef struct packed {
      logic              load_stb;
      logic              at_pps;
      logic [TIME_W-1:0] value;
   } time_set_t;

endpackage

// ==== project.f ====
common/radio_pkg.sv
radio_ctrl/radio_settings.sv
radio_ctrl/radio_readback.sv
src/timekeeper.sv
tx_wave/tx_codeword_gen.sv
src/radio_core.sv
bench/tb_clock_gen.sv
bench/radio_core_sva.sv
bench/radio_core_tb.sv

// ==== radio_ctrl/radio_readback.sv ====
/*
 * Readback multiplexer
 * Registers the source picked by the readback select and forms
 * the receive word, looped back from transmit when asked
 */
`timescale 1ns/1ps

module radio_readback import radio_pkg::*; (
   input  logic              i_clk,
   input  logic              i_arst_n,
   input  rb_sel_e           i_rb_sel,
   input  logic [DATA_W-1:0] i_test_word,
   input  logic [TIME_W-1:0] i_vita_time,
   input  logic [TIME_W-1:0] i_vita_time_pps,
   input  logic [DATA_W-1:0] i_tx,
   input  logic [DATA_W-1:0] i_rx,
   input  logic              i_loopback,
   output logic [TIME_W-1:0] o_rb_data
);

   logic [DATA_W-1:0] rx_word;

   // Digital loopback TX -> RX
   assign rx_word = i_loopback ? i_tx : i_rx;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rb_data <= '0;
      end else begin
         case (i_rb_sel)
            RB_TEST:     o_rb_data <= {{(TIME_W-DATA_W){1'b0}}, i_test_word};
            RB_TIME:     o_rb_data <= i_vita_time;
            RB_TIME_PPS: o_rb_data <= i_vita_time_pps;
            RB_SAMPLES:  o_rb_data <= {i_tx, rx_word};
            default:     o_rb_data <= '0;   // RB_ZERO and unused codes
         endcase
      end
   end

endmodule

// ==== radio_ctrl/radio_settings.sv ====
/*
 * Radio settings registers
 * Decodes the settings bus into the control, test, idle, loopback,
 * readback select and codeword registers, and issues time loads
 */
`timescale 1ns/1ps

module radio_settings import radio_pkg::*; (
   input  logic                                i_clk,
   input  logic                                i_arst_n,
   input  set_bus_t                            i_set,
   output tx_ctrl_t                            o_tx_ctrl,
   output logic [DATA_W-1:0]                   o_idle_word,
   output logic [N_CODEWORDS-1:0][DATA_W-1:0]  o_codewords,
   output time_set_t                           o_time_set,
   output logic                                o_loopback,
   output logic [DATA_W-1:0]                   o_test_word,
   output rb_sel_e                             o_rb_sel
);

   logic [DATA_W-1:0] time_hi;    // Upper half waiting for the low write
   logic              time_at_pps;
   logic [ADDR_W-1:0] cw_off;
   logic              cw_hit;

   // Offset into the codeword table, wraps below SR_CODEWORD0
   assign cw_off = i_set.addr - SR_CODEWORD0;
   assign cw_hit = cw_off < ADDR_W'(N_CODEWORDS);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_tx_ctrl   <= '0;
         o_idle_word <= '0;
         o_codewords <= '0;
         o_time_set  <= '0;
         o_loopback  <= 1'b0;
         o_test_word <= '0;
         o_rb_sel    <= RB_TEST;
         time_hi     <= '0;
         time_at_pps <= 1'b0;
      end else begin
         o_time_set.load_stb <= 1'b0;   // Pulse only

         if (i_set.stb) begin
            case (i_set.addr)
               SR_LOOPBACK:   o_loopback  <= i_set.data[0];
               SR_TEST:       o_test_word <= i_set.data;
               SR_CODEC_IDLE: o_idle_word <= i_set.data;
               SR_READBACK:   o_rb_sel    <= rb_sel_e'(i_set.data[2:0]);
               SR_TIME_HI:    time_hi     <= i_set.data;
               SR_TIME_CTRL:  time_at_pps <= i_set.data[0];
               SR_TIME_LO: begin
                  o_time_set.load_stb <= 1'b1;
                  o_time_set.at_pps   <= time_at_pps;
                  o_time_set.value    <= {time_hi, i_set.data};
               end
               SR_CNTRL: begin
                  o_tx_ctrl.wave_rst <= i_set.data[0];
                  o_tx_ctrl.run      <= i_set.data[1];
                  o_tx_ctrl.length   <= i_set.data[12:8];
               end
               default: begin
                  if (cw_hit)
                     o_codewords[cw_off[CW_IDX_W-1:0]] <= i_set.data;
               end
            endcase
         end
      end
   end

endmodule

// ==== src/radio_core.sv ====
/*
 * Radio control core
 * Settings registers, timekeeper, codeword source and readback
 */
`timescale 1ns/1ps

module radio_core import radio_pkg::*; (
   input  logic              bus_clk,
   input  logic              i_arst_n,
   input  set_bus_t          i_set,
   input  logic [DATA_W-1:0] i_rx,
   input  logic              i_pps,
   output logic [DATA_W-1:0] o_tx,
   output logic [TIME_W-1:0] o_rb_data,
   output logic [TIME_W-1:0] o_vita_time
);

   tx_ctrl_t                           tx_ctrl;
   logic [DATA_W-1:0]                  idle_word;
   logic [N_CODEWORDS-1:0][DATA_W-1:0] codewords;
   time_set_t                          time_set;
   logic                               loopback;
   logic [DATA_W-1:0]                  test_word;
   rb_sel_e                            rb_sel;
   logic [TIME_W-1:0]                  vita_time_pps;

   //////////////////////////////
   // Settings and time
   //////////////////////////////
   radio_settings u_settings (
      .i_clk       (bus_clk),
      .i_arst_n    (i_arst_n),
      .i_set       (i_set),
      .o_tx_ctrl   (tx_ctrl),
      .o_idle_word (idle_word),
      .o_codewords (codewords),
      .o_time_set  (time_set),
      .o_loopback  (loopback),
      .o_test_word (test_word),
      .o_rb_sel    (rb_sel)
   );

   timekeeper u_timekeeper (
      .i_clk           (bus_clk),
      .i_arst_n        (i_arst_n),
      .i_pps           (i_pps),
      .i_time_set      (time_set),
      .o_vita_time     (o_vita_time),
      .o_vita_time_pps (vita_time_pps)
   );

   //////////////////////////////
   // Transmit and readback
   //////////////////////////////
   tx_codeword_gen u_tx_gen (
      .i_clk       (bus_clk),
      .i_arst_n    (i_arst_n),
      .i_tx_ctrl   (tx_ctrl),
      .i_idle_word (idle_word),
      .i_codewords (codewords),
      .o_tx        (o_tx)
   );

   radio_readback u_readback (
      .i_clk           (bus_clk),
      .i_arst_n        (i_arst_n),
      .i_rb_sel        (rb_sel),
      .i_test_word     (test_word),
      .i_vita_time     (o_vita_time),
      .i_vita_time_pps (vita_time_pps),
      .i_tx            (o_tx),          // Also the loopback source
      .i_rx            (i_rx),
      .i_loopback      (loopback),
      .o_rb_data       (o_rb_data)
   );

endmodule

// ==== src/timekeeper.sv ====
/*
 * Timekeeper
 * Free running time counter, loaded at once or at the next PPS
 * rising edge, and capturing its value at every PPS edge
 */
`timescale 1ns/1ps

module timekeeper import radio_pkg::*; (
   input  logic              i_clk,
   input  logic              i_arst_n,
   input  logic              i_pps,
   input  time_set_t         i_time_set,
   output logic [TIME_W-1:0] o_vita_time,
   output logic [TIME_W-1:0] o_vita_time_pps
);

   logic              pps_d;
   logic              pps_edge;
   logic              armed;        // Load waiting for PPS
   logic [TIME_W-1:0] armed_time;

   assign pps_edge = i_pps & ~pps_d;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pps_d           <= 1'b0;
         armed           <= 1'b0;
         o_vita_time     <= '0;
         o_vita_time_pps <= '0;
      end else begin
         pps_d <= i_pps;

         if (pps_edge)
            o_vita_time_pps <= o_vita_time;   // Time at last PPS

         if (i_time_set.load_stb && !i_time_set.at_pps)
            o_vita_time <= i_time_set.value;
         else if (pps_edge && armed)
            o_vita_time <= armed_time;
         else
            o_vita_time <= o_vita_time + 1'b1;

         // A new load replaces any armed one
         if (i_time_set.load_stb)
            armed <= i_time_set.at_pps;
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_time_set.load_stb && i_time_set.at_pps)
         armed_time <= i_time_set.value;
   end

endmodule

// ==== tx_wave/tx_codeword_gen.sv ====
/*
 * Transmit codeword source
 * Plays the codeword table in a loop while running, otherwise
 * sends the codec idle word
 */
`timescale 1ns/1ps

module tx_codeword_gen import radio_pkg::*; (
   input  logic                                i_clk,
   input  logic                                i_arst_n,
   input  tx_ctrl_t                            i_tx_ctrl,
   input  logic [DATA_W-1:0]                   i_idle_word,
   input  logic [N_CODEWORDS-1:0][DATA_W-1:0]  i_codewords,
   output logic [DATA_W-1:0]                   o_tx
);

   logic                active;
   logic [CW_IDX_W-1:0] len_eff;
   logic [CW_IDX_W-1:0] cw_idx;

   assign active = i_tx_ctrl.run & ~i_tx_ctrl.wave_rst;

   // Zero or out of range length plays the whole table
   assign len_eff = (i_tx_ctrl.length == '0 || i_tx_ctrl.length > CW_IDX_W'(N_CODEWORDS)) ?
                    CW_IDX_W'(N_CODEWORDS) : i_tx_ctrl.length;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cw_idx <= '0;
         o_tx   <= '0;
      end else begin
         if (!active)
            cw_idx <= '0;
         else if (cw_idx >= len_eff - 1'b1)   // Also catches a shortened length
            cw_idx <= '0;
         else
            cw_idx <= cw_idx + 1'b1;

         o_tx <= active ? i_codewords[cw_idx] : i_idle_word;
      end
   end

endmodule
